// File: common/hs_pkg.sv
`default_nettype none

package hs_pkg;

  // ----------------------------------------
  // sizes
  localparam int NUM_SLOTS     = 8;
  localparam int SLOT_W        = 3;
  localparam int LEN_W         = 22;     // stored length, words
  localparam int BYTE_LEN_W    = 24;     // cpu length, bytes
  localparam int ADDR_W        = 32;     // word address
  localparam int MAX_BLOCK     = 64;
  localparam int BLK_W         = 7;
  localparam int PAGE_WORDS    = 4096;
  localparam int PAGE_W        = $clog2(PAGE_WORDS);
  localparam int POLL_INTERVAL = 8;      // cycles per slot
  localparam int POLL_W        = $clog2(POLL_INTERVAL);

  // block scheduler states
  localparam logic [2:0] SCH_IDLE = 3'd0;
  localparam logic [2:0] SCH_GO   = 3'd1;  // go up, waiting for ready to drop
  localparam logic [2:0] SCH_WAIT = 3'd2;  // block in the executor
  localparam logic [2:0] SCH_WB   = 3'd3;
  localparam logic [2:0] SCH_IRQ  = 3'd4;

  // page splitter states
  localparam logic [1:0] PS_IDLE = 2'd0;
  localparam logic [1:0] PS_ARM  = 2'd1;
  localparam logic [1:0] PS_WAIT = 2'd2;

  // ----------------------------------------
  // descriptor as stored
  typedef struct packed {
    logic              active;
    logic              dir;
    logic [1:0]        section;
    logic [1:0]        spare;
    logic [LEN_W-1:0]  len;
    logic [3:0]        pad;
    logic [ADDR_W-1:0] addr;
  } desc_t;

  typedef union packed {
    desc_t            f;
    logic [1:0][31:0] half;   // half[1]: flags and length
  } desc_word_u;

  // descriptor as written by the cpu
  typedef struct packed {
    logic                  active;
    logic                  dir;
    logic [1:0]            section;
    logic [3:0]            spare;
    logic [BYTE_LEN_W-1:0] byte_len;
    logic [ADDR_W-1:0]     addr;
  } cpu_word_t;

  // ----------------------------------------
  // ports
  typedef struct packed {
    logic              rd;
    logic              wr;
    logic [SLOT_W-1:0] slot;
    cpu_word_t         data;
  } cpu_req_t;

  typedef struct packed {
    logic        wr_ack;
    logic        rd_ack;
    logic [31:0] rdata;
  } cpu_rsp_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [BLK_W-1:0]  count;
    logic [1:0]        section;
    logic              dir;
    logic [SLOT_W-1:0] slot;
  } blk_cmd_t;

  typedef struct packed {
    logic              issue;
    logic [ADDR_W-1:0] addr;
    logic [BLK_W-1:0]  count;
    logic [1:0]        section;
    logic              dir;
  } mover_cmd_t;

  typedef struct packed {
    logic             done;
    logic [BLK_W-1:0] count_sent;
    logic             abort;
  } mover_rsp_t;

  typedef struct packed {
    logic              we;
    logic [SLOT_W-1:0] slot;
    desc_t             desc;
  } wb_t;

endpackage

`default_nettype wire

// File: hw/desc_mem/desc_mem.sv
`timescale 1ns/10ps
`default_nettype none

module desc_mem
(
  input  wire                       CLK,
  input  wire                       RST,
  input  wire hs_pkg::cpu_req_t     cpu_req,
  output hs_pkg::cpu_rsp_t          cpu_rsp,
  input  wire [hs_pkg::SLOT_W-1:0]  rd_slot,
  output hs_pkg::desc_word_u        rd_data,
  input  wire hs_pkg::wb_t          wb
);
  import hs_pkg::*;

  desc_t             mem [NUM_SLOTS];
  desc_t             cpu_desc;
  logic [LEN_W-1:0]  cpu_words;
  logic              wr_go;
  logic              rd_go;
  logic              wr_ack;
  logic              rd_ack;
  logic [SLOT_W-1:0] cpu_rd_slot;
  desc_word_u        cpu_rd_word;
  logic [31:0]       rdata;

  // ----------------------------------------
  // cpu write word to stored descriptor

  // bytes to words, rounded up
  assign cpu_words = cpu_req.data.byte_len[BYTE_LEN_W-1:2] +
                     LEN_W'(|cpu_req.data.byte_len[1:0]);

  always_comb
  begin
    cpu_desc         = '0;
    cpu_desc.active  = cpu_req.data.active;
    cpu_desc.dir     = cpu_req.data.dir;
    cpu_desc.section = cpu_req.data.section;
    cpu_desc.len     = cpu_words;
    cpu_desc.addr    = cpu_req.data.addr;
  end

  // ----------------------------------------
  // arbitration, write-back first

  assign wr_go = cpu_req.wr && !wr_ack && !wb.we;
  assign rd_go = cpu_req.rd && !rd_ack && !wb.we &&
                 !(cpu_req.wr && !wr_ack);   // pending write goes first

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      for (int i = 0; i < NUM_SLOTS; i++)
        mem[i] <= '0;
      wr_ack <= 1'b0;
      rd_ack <= 1'b0;
    end
    else
    begin
      if (wb.we)
        mem[wb.slot] <= wb.desc;
      else if (wr_go)
        mem[cpu_req.slot] <= cpu_desc;
      wr_ack <= wr_go;  // one cycle pulse, request still held
      rd_ack <= rd_go;
    end
  end

  // ----------------------------------------
  // read ports

  assign cpu_rd_word.f = mem[cpu_rd_slot];

  always_ff @(posedge CLK)
  begin
    rd_data.f <= mem[rd_slot];   // scheduler port, one cycle latency
    if (rd_go)
      cpu_rd_slot <= cpu_req.slot;
    if (rd_ack)
      rdata <= cpu_rd_word.half[1];  // valid the cycle after rd_ack
  end

  assign cpu_rsp = '{wr_ack: wr_ack, rd_ack: rd_ack, rdata: rdata};

  // one cpu access acknowledged at a time
  a_ack_excl: assert property (@(posedge CLK) disable iff (!RST)
                               !(cpu_rsp.wr_ack && cpu_rsp.rd_ack));

endmodule

`default_nettype wire

// File: hw/scheduler/slot_poller.sv
`timescale 1ns/10ps
`default_nettype none

module slot_poller
(
  input  wire                        CLK,
  input  wire                        RST,
  input  wire [3:0]                  chan_ready,
  input  wire                        busy,
  output logic [hs_pkg::SLOT_W-1:0]  rd_slot,
  input  wire hs_pkg::desc_word_u    rd_data,
  output logic                       cand_valid,
  output logic [hs_pkg::SLOT_W-1:0]  cand_slot,
  output hs_pkg::desc_t              cand_desc
);
  import hs_pkg::*;

  logic [POLL_W-1:0] poll_cnt;
  logic              look;      // rd_data belongs to the slot just selected

  // ----------------------------------------
  // carousel

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      poll_cnt  <= '0;
      rd_slot   <= '0;
      look      <= 1'b0;
      cand_slot <= '0;
    end
    else
    begin
      if (poll_cnt == POLL_W'(POLL_INTERVAL - 1))
      begin
        poll_cnt <= '0;
        rd_slot  <= rd_slot + 1'b1;  // wraps after the last slot
      end
      else
        poll_cnt <= poll_cnt + 1'b1;

      // read issued this cycle, data next cycle
      look      <= (poll_cnt == '0);
      cand_slot <= rd_slot;
    end
  end

  // ----------------------------------------
  // qualification

  assign cand_desc  = rd_data.f;
  assign cand_valid = look && cand_desc.active &&
                      chan_ready[cand_desc.section] &&
                      !busy;

endmodule

`default_nettype wire

// File: hw/scheduler/block_scheduler.sv
`timescale 1ns/10ps
`default_nettype none

module block_scheduler
(
  input  wire                        CLK,
  input  wire                        RST,
  input  wire                        cand_valid,
  input  wire [hs_pkg::SLOT_W-1:0]   cand_slot,
  input  wire hs_pkg::desc_t         cand_desc,
  output logic                       busy,
  output logic                       go,
  output hs_pkg::blk_cmd_t           cmd,
  input  wire                        ready,
  input  wire [hs_pkg::BLK_W-1:0]    sent_count,
  input  wire                        restart,
  input  wire                        aborted,
  output hs_pkg::wb_t                wb,
  output logic                       irq,
  output logic [hs_pkg::SLOT_W-1:0]  irq_slot
);
  import hs_pkg::*;

  logic [2:0]        state;
  desc_t             cur;       // working addr and remaining len
  logic [SLOT_W-1:0] slot;
  logic [BLK_W-1:0]  blk;       // words asked of the executor
  logic              fin;       // last write-back of this transfer
  logic              wb_we;
  desc_t             wb_desc;
  desc_t             wb_next;
  logic [ADDR_W-1:0] new_addr;
  logic [LEN_W-1:0]  new_len;
  logic              finish;
  logic              take;
  logic              blk_done;
  logic              next_blk;

  function automatic logic [BLK_W-1:0] block_of(input logic [LEN_W-1:0] len);
    if (len > LEN_W'(MAX_BLOCK))
      return BLK_W'(MAX_BLOCK);
    else
      return len[BLK_W-1:0];
  endfunction

  assign take     = (state == SCH_IDLE) && cand_valid;
  assign blk_done = (state == SCH_WAIT) && ready;
  assign next_blk = (state == SCH_WB) && !fin;

  assign new_addr = cur.addr + ADDR_W'(sent_count);
  assign new_len  = cur.len - LEN_W'(sent_count);
  assign finish   = aborted || (new_len == '0);

  always_comb
  begin
    wb_next        = cur;
    wb_next.active = !finish;
    wb_next.len    = new_len;
    wb_next.addr   = new_addr;
  end

  // ----------------------------------------
  // control

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      state <= SCH_IDLE;
      go    <= 1'b0;
      wb_we <= 1'b0;
      fin   <= 1'b0;
      irq   <= 1'b0;
    end
    else
    begin
      case (state)
        SCH_IDLE:
          if (cand_valid)
          begin
            if (cand_desc.len == '0)
            begin
              wb_we <= 1'b1;   // nothing to move, just retire the slot
              fin   <= 1'b1;
              state <= SCH_WB;
            end
            else
            begin
              go    <= 1'b1;
              state <= SCH_GO;
            end
          end
        SCH_GO:
          if (!ready)
          begin
            go    <= 1'b0;
            state <= SCH_WAIT;
          end
        SCH_WAIT:
          if (ready)
          begin
            if (restart)
            begin
              go    <= 1'b1;   // rest of the cut block, no write-back
              state <= SCH_GO;
            end
            else
            begin
              wb_we <= 1'b1;
              fin   <= finish;
              state <= SCH_WB;
            end
          end
        SCH_WB:
        begin
          wb_we <= 1'b0;
          if (fin)
          begin
            irq   <= 1'b1;
            state <= SCH_IRQ;
          end
          else
          begin
            go    <= 1'b1;
            state <= SCH_GO;
          end
        end
        SCH_IRQ:
        begin
          irq   <= 1'b0;
          state <= SCH_IDLE;  // slot already written back inactive
        end
        default:
          state <= SCH_IDLE;
      endcase
    end
  end

  // ----------------------------------------
  // working registers

  always_ff @(posedge CLK)
  begin
    if (take)
    begin
      cur            <= cand_desc;
      slot           <= cand_slot;
      blk            <= block_of(cand_desc.len);
      wb_desc        <= cand_desc;
      wb_desc.active <= 1'b0;
    end
    if (blk_done)
    begin
      cur.addr <= new_addr;
      cur.len  <= new_len;
      blk      <= blk - sent_count;  // only reissued on restart
      wb_desc  <= wb_next;
    end
    if (next_blk)
      blk <= block_of(cur.len);
  end

  assign busy     = (state != SCH_IDLE);
  assign irq_slot = slot;
  assign cmd      = '{addr: cur.addr, count: blk, section: cur.section,
                      dir: cur.dir, slot: slot};
  assign wb       = '{we: wb_we, slot: slot, desc: wb_desc};

  // the slot is never read for a new block while its write-back is open
  a_go_wb: assert property (@(posedge CLK) disable iff (!RST) !(go && wb.we));

endmodule

`default_nettype wire

// File: hw/block_exec/page_splitter.sv
`timescale 1ns/10ps
`default_nettype none

module page_splitter
(
  input  wire                       CLK,
  input  wire                       RST,
  input  wire                       go,
  input  wire hs_pkg::blk_cmd_t     cmd,
  output logic                      ready,
  output logic [hs_pkg::BLK_W-1:0]  sent_count,
  output logic                      restart,
  output logic                      aborted,
  output hs_pkg::mover_cmd_t        mover_cmd,
  input  wire hs_pkg::mover_rsp_t   mover_rsp
);
  import hs_pkg::*;

  logic [1:0]        state;
  blk_cmd_t          blk;        // latched block command
  logic [PAGE_W:0]   room;       // words left in the start page
  logic              cut;
  logic              cut_r;
  logic [BLK_W-1:0]  req;
  logic [BLK_W-1:0]  req_r;
  logic              issue;

  // ----------------------------------------
  // page cut

  assign room = PAGE_WORDS[PAGE_W:0] - {1'b0, blk.addr[PAGE_W-1:0]};
  assign cut  = {{(PAGE_W + 1 - BLK_W){1'b0}}, blk.count} > room;
  assign req  = cut ? room[BLK_W-1:0] : blk.count;  // room < count here

  // ----------------------------------------
  // control

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      state   <= PS_IDLE;
      issue   <= 1'b0;
      restart <= 1'b0;
      aborted <= 1'b0;
    end
    else
    begin
      case (state)
        PS_IDLE:
          if (go)
            state <= PS_ARM;
        PS_ARM:
        begin
          issue <= 1'b1;
          state <= PS_WAIT;
        end
        PS_WAIT:
        begin
          issue <= 1'b0;   // single cycle issue
          if (mover_rsp.done)
          begin
            // full cut block sent, rest goes at the next page
            restart <= cut_r && (mover_rsp.count_sent == req_r) &&
                       !mover_rsp.abort;
            aborted <= mover_rsp.abort;
            state   <= PS_IDLE;
          end
        end
        default:
          state <= PS_IDLE;
      endcase
    end
  end

  // ----------------------------------------
  // datapath

  always_ff @(posedge CLK)
  begin
    if (ready && go)
      blk <= cmd;
    if (state == PS_ARM)
    begin
      req_r <= req;
      cut_r <= cut;
    end
    if ((state == PS_WAIT) && mover_rsp.done)
      sent_count <= mover_rsp.count_sent;
  end

  assign ready     = (state == PS_IDLE);
  assign mover_cmd = '{issue: issue, addr: blk.addr, count: req_r,
                       section: blk.section, dir: blk.dir};

  // mover only answers a block that was issued
  a_done_busy: assert property (@(posedge CLK) disable iff (!RST)
                                mover_rsp.done |-> !ready);

endmodule

`default_nettype wire

// File: hw/hyper_top.sv
`timescale 1ns/10ps
`default_nettype none

module hyper_top
(
  input  wire                        CLK,
  input  wire                        RST,
  input  wire hs_pkg::cpu_req_t      cpu_req,
  output wire hs_pkg::cpu_rsp_t      cpu_rsp,
  input  wire [3:0]                  chan_ready,
  output wire hs_pkg::mover_cmd_t    mover_cmd,
  input  wire hs_pkg::mover_rsp_t    mover_rsp,
  output wire                        irq,
  output wire [hs_pkg::SLOT_W-1:0]   irq_slot
);
  import hs_pkg::*;

  // descriptor store side
  logic [SLOT_W-1:0] rd_slot;
  desc_word_u        rd_data;
  wb_t               wb;

  // poller to scheduler
  logic              cand_valid;
  logic [SLOT_W-1:0] cand_slot;
  desc_t             cand_desc;
  logic              busy;

  // scheduler to executor
  logic              go;
  blk_cmd_t          cmd;
  logic              ready;
  logic [BLK_W-1:0]  sent_count;
  logic              restart;
  logic              aborted;

  desc_mem u_desc_mem
  (
    .CLK     (CLK),
    .RST     (RST),
    .cpu_req (cpu_req),
    .cpu_rsp (cpu_rsp),
    .rd_slot (rd_slot),
    .rd_data (rd_data),
    .wb      (wb)
  );

  slot_poller u_slot_poller
  (
    .CLK        (CLK),
    .RST        (RST),
    .chan_ready (chan_ready),
    .busy       (busy),
    .rd_slot    (rd_slot),
    .rd_data    (rd_data),
    .cand_valid (cand_valid),
    .cand_slot  (cand_slot),
    .cand_desc  (cand_desc)
  );

  block_scheduler u_block_scheduler
  (
    .CLK        (CLK),
    .RST        (RST),
    .cand_valid (cand_valid),
    .cand_slot  (cand_slot),
    .cand_desc  (cand_desc),
    .busy       (busy),
    .go         (go),
    .cmd        (cmd),
    .ready      (ready),
    .sent_count (sent_count),
    .restart    (restart),
    .aborted    (aborted),
    .wb         (wb),
    .irq        (irq),
    .irq_slot   (irq_slot)
  );

  page_splitter u_page_splitter
  (
    .CLK        (CLK),
    .RST        (RST),
    .go         (go),
    .cmd        (cmd),
    .ready      (ready),
    .sent_count (sent_count),
    .restart    (restart),
    .aborted    (aborted),
    .mover_cmd  (mover_cmd),
    .mover_rsp  (mover_rsp)
  );

endmodule

`default_nettype wire

// File: test/tb_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen
#(
  parameter int HALF_PERIOD = 10,   // 20 ns clock
  parameter int RST_CYCLES  = 16
)
(
  output logic CLK,
  output logic RST
);

  initial
  begin
    CLK = 1'b0;
    forever
      #(HALF_PERIOD) CLK = ~CLK;
  end

  // reset low, released just after an edge
  initial
  begin
    RST = 1'b0;
    repeat (RST_CYCLES) @(posedge CLK);
    #2;
    RST = 1'b1;
  end

endmodule

`default_nettype wire

// File: test/tb_hyper.sv
`timescale 1ns/10ps
`default_nettype none

module tb_hyper;
  import hs_pkg::*;

  localparam int REC_WORDS  = 5;      // type plus four arguments
  localparam int MAX_RECS   = 64;
  localparam int REC_CYCLES = 2000;   // watchdog budget per record

  logic              CLK;
  logic              RST;
  cpu_req_t          cpu_req;
  cpu_rsp_t          cpu_rsp;
  logic [3:0]        chan_ready;
  mover_cmd_t        mover_cmd;
  mover_rsp_t        mover_rsp;
  logic              irq;
  logic [SLOT_W-1:0] irq_slot;

  logic [31:0]       stim [REC_WORDS * MAX_RECS];
  int                num_recs;
  int                abort_after;   // 0 means the mover sends every word
  integer            seed;
  mover_cmd_t        exp_cmds [$];
  logic [SLOT_W-1:0] irq_seen [$];

  tb_clk_gen u_tb_clk_gen
  (
    .CLK (CLK),
    .RST (RST)
  );

  hyper_top u_hyper_top
  (
    .CLK        (CLK),
    .RST        (RST),
    .cpu_req    (cpu_req),
    .cpu_rsp    (cpu_rsp),
    .chan_ready (chan_ready),
    .mover_cmd  (mover_cmd),
    .mover_rsp  (mover_rsp),
    .irq        (irq),
    .irq_slot   (irq_slot)
  );

  // ----------------------------------------
  // compare tasks

  task automatic end_with_failure();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_mover_cmd(input mover_cmd_t got, input mover_cmd_t want);
    if (got !== want)
    begin
      $display("CHECK FAILED at %0t ns: mover_cmd got %h/%0d/%0d/%0d expected %h/%0d/%0d/%0d",
               $time, got.addr, got.count, got.section, got.dir,
               want.addr, want.count, want.section, want.dir);
      end_with_failure();
    end
  endtask

  task automatic check_cpu_rdata(input desc_word_u got, input desc_word_u want);
    if (got.half[1] !== want.half[1])
    begin
      $display("CHECK FAILED at %0t ns: cpu_rsp.rdata got %h expected %h",
               $time, got.half[1], want.half[1]);
      end_with_failure();
    end
  endtask

  task automatic check_irq_slot(input logic [SLOT_W-1:0] got,
                                input logic [SLOT_W-1:0] want);
    if (got !== want)
    begin
      $display("CHECK FAILED at %0t ns: irq_slot got %0d expected %0d", $time, got, want);
      end_with_failure();
    end
  endtask

  // ----------------------------------------
  // cpu port

  task automatic cpu_write(input logic [SLOT_W-1:0]     slot,
                           input logic [3:0]            flags,
                           input logic [BYTE_LEN_W-1:0] byte_len,
                           input logic [ADDR_W-1:0]     addr);
    cpu_word_t w;
    w          = '0;
    w.active   = flags[3];
    w.dir      = flags[2];
    w.section  = flags[1:0];
    w.byte_len = byte_len;
    w.addr     = addr;
    @(posedge CLK);
    #2;
    cpu_req.wr   = 1'b1;
    cpu_req.slot = slot;
    cpu_req.data = w;
    do
    begin
      @(posedge CLK);
      #1;
    end
    while (!cpu_rsp.wr_ack);
    #1;
    cpu_req.wr = 1'b0;   // held until the ack
  endtask

  task automatic cpu_read(input logic [SLOT_W-1:0] slot, input logic [31:0] upper);
    desc_word_u got;
    desc_word_u want;
    @(posedge CLK);
    #2;
    cpu_req.rd   = 1'b1;
    cpu_req.slot = slot;
    do
    begin
      @(posedge CLK);
      #1;
    end
    while (!cpu_rsp.rd_ack);
    #1;
    cpu_req.rd = 1'b0;
    @(posedge CLK);      // rdata one cycle after the ack
    #1;
    got.half[1]  = cpu_rsp.rdata;
    got.half[0]  = '0;
    want.half[1] = upper;
    want.half[0] = '0;
    check_cpu_rdata(got, want);
  endtask

  task automatic wait_irq(input logic [SLOT_W-1:0] slot);
    while (irq_seen.size() == 0)
      @(posedge CLK);
    if (exp_cmds.size() != 0)
    begin
      $display("ERROR: interrupt came before all blocks of slot %0d were issued", slot);
      end_with_failure();
    end
    check_irq_slot(irq_seen.pop_front(), slot);
  endtask

  // ----------------------------------------
  // block mover model

  initial
  begin
    mover_cmd_t       want;
    int               delay;
    logic [BLK_W-1:0] sent;
    logic             cut_short;
    mover_rsp = '0;
    forever
    begin
      @(posedge CLK);
      #1;
      if (mover_cmd.issue)
      begin
        if (exp_cmds.size() == 0)
        begin
          $display("ERROR: mover command at %0t ns with none expected, addr %h count %0d",
                   $time, mover_cmd.addr, mover_cmd.count);
          end_with_failure();
        end
        want = exp_cmds.pop_front();
        check_mover_cmd(mover_cmd, want);
        cut_short = (abort_after != 0) && (abort_after < int'(want.count));
        sent      = cut_short ? BLK_W'(abort_after) : want.count;
        delay     = 1 + ($unsigned($random(seed)) % 9);
        repeat (delay) @(posedge CLK);
        #2;
        mover_rsp.done       = 1'b1;
        mover_rsp.count_sent = sent;
        mover_rsp.abort      = cut_short;
        @(posedge CLK);
        #2;
        mover_rsp = '0;
      end
    end
  end

  // interrupt pulses, kept in order
  always
  begin
    @(posedge CLK);
    #1;
    if (irq)
      irq_seen.push_back(irq_slot);
  end

  // ----------------------------------------
  // watchdog

  initial
  begin
    wait (RST === 1'b1);
    repeat ((num_recs + 1) * REC_CYCLES) @(posedge CLK);
    $display("ERROR: timeout after %0d cycles, %0d records", (num_recs + 1) * REC_CYCLES,
             num_recs);
    end_with_failure();
  end

  // ----------------------------------------
  // stimulus records

  initial
  begin
    int          op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    mover_cmd_t  cmd;
    cpu_req     = '0;
    chan_ready  = '0;
    abort_after = 0;
    seed        = 48;
    num_recs    = 0;
    $readmemh("test/hyper_stim.txt", stim);
    while ((num_recs < MAX_RECS) && (stim[num_recs * REC_WORDS] != '0))
      num_recs++;
    if (num_recs == 0)
    begin
      $display("ERROR: no stimulus records read from test/hyper_stim.txt");
      end_with_failure();
    end
    wait (RST === 1'b1);

    for (int r = 0; r < num_recs; r++)
    begin
      op = stim[r * REC_WORDS];
      a  = stim[r * REC_WORDS + 1];
      b  = stim[r * REC_WORDS + 2];
      c  = stim[r * REC_WORDS + 3];
      d  = stim[r * REC_WORDS + 4];
      case (op)
        1: cpu_write(a[SLOT_W-1:0], b[3:0], c[BYTE_LEN_W-1:0], d);
        2: cpu_read(a[SLOT_W-1:0], b);
        3:
        begin
          @(posedge CLK);
          #2;
          chan_ready = a[3:0];
        end
        4: abort_after = a;
        5:
        begin
          cmd = '{issue: 1'b1, addr: a, count: b[BLK_W-1:0], section: c[1:0], dir: d[0]};
          exp_cmds.push_back(cmd);
        end
        6: wait_irq(a[SLOT_W-1:0]);
        7: repeat (a) @(posedge CLK);
        default:
        begin
          $display("ERROR: unknown record type %0d in record %0d", op, r);
          end_with_failure();
        end
      endcase
    end

    repeat (20) @(posedge CLK);   // let stray commands or interrupts show up
    if ((exp_cmds.size() != 0) || (irq_seen.size() != 0))
    begin
      $display("ERROR: %0d expected mover commands missing, %0d interrupts unaccounted",
               exp_cmds.size(), irq_seen.size());
      end_with_failure();
    end
    else
    begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: test/hyper_stim.txt
// type arg1 arg2 arg3 arg4, hex. 1 write: slot flags(act,dir,sec) bytes addr. 2 read: slot upper
// 3 chan_ready mask. 4 mover abort after N words. 5 expect cmd: addr count sec dir. 6 irq slot. 7 idle
// write then read, bytes rounded up to words
1 0 6 64 1000
2 0 60000190 0 0
1 1 1 65 1100
2 1 100001A0 0 0
// 150 words in blocks of 64, 64, 22
3 F 0 0 0
4 0 0 0 0
5 100 40 3 1
5 140 40 3 1
5 180 16 3 1
1 2 F 258 100
6 2 0 0 0
2 2 70000000 0 0
// block cut 10 words before a page boundary
5 FF6 A 1 0
5 1000 36 1 0
1 3 9 100 FF6
6 3 0 0 0
2 3 10000000 0 0
// section not ready, then released
3 D 0 0 0
1 4 D A0 2000
7 C8 0 0 0
2 4 D0000280 0 0
5 2000 28 1 1
3 F 0 0 0
6 4 0 0 0
// mover aborts after 5 words
4 5 0 0 0
5 3000 40 2 0
1 5 A 100 3000
6 5 0 0 0
2 5 200003B0 0 0
4 0 0 0 0
0 0 0 0 0

// File: src.f
common/hs_pkg.sv
hw/desc_mem/desc_mem.sv
hw/scheduler/slot_poller.sv
hw/scheduler/block_scheduler.sv
hw/block_exec/page_splitter.sv
hw/hyper_top.sv
test/tb_clk_gen.sv
test/tb_hyper.sv

// File: run_sim.sh
#!/bin/sh
# build and run tb_hyper with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_hyper -f src.f \
  --Mdir obj_dir -o sim_hyper

./obj_dir/sim_hyper > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "FAIL: see errors above" "$LOG"; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "PASS: all tests" "$LOG"; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"
